//--- rsa_pkg.sv
`default_nettype none

package rsa_pkg;

	// key width used when no override is given
	localparam int DEFAULT_WIDTH = 256;

	// exponentiation controller
	typedef enum logic [2:0] {
		CORE_IDLE,
		CORE_PREP,     // mapping text into montgomery domain
		CORE_PREMONT,  // issue multiplier starts
		CORE_MONT,     // wait for multipliers
		CORE_CALC      // take results, next bit
	} core_state_e;

	// serial arithmetic units
	typedef enum logic [1:0] {
		UNIT_IDLE,
		UNIT_RUN,
		UNIT_DONE
	} unit_state_e;

endpackage

`default_nettype wire

//--- rsa_key_regs.sv
`timescale 1ns/100ps
`default_nettype none

module rsa_key_regs #(
	parameter int WIDTH = rsa_pkg::DEFAULT_WIDTH
) (
	input  wire              i_clk,
	input  wire              i_rst,
	input  wire              i_key_load,
	input  wire [WIDTH-1:0]  i_n,
	input  wire [WIDTH-1:0]  i_d,
	input  wire              i_busy,
	output logic [WIDTH-1:0] o_n,
	output logic [WIDTH-1:0] o_d
);

	logic [WIDTH-1:0] n_r;
	logic [WIDTH-1:0] d_r;
	logic             load_ok;

	// key stays fixed for the whole run
	assign load_ok = i_key_load && !i_busy;

	always_ff @(posedge i_clk or posedge i_rst) begin
		if (i_rst) begin
			n_r <= '0;
			d_r <= '0;
		end else if (load_ok) begin
			n_r <= i_n;
			d_r <= i_d;
		end
	end

	assign o_n = n_r;
	assign o_d = d_r;

endmodule

`default_nettype wire

//--- rsa_mod_prod.sv
`timescale 1ns/100ps
`default_nettype none

// computes b * 2^WIDTH mod n by repeated doubling
module rsa_mod_prod #(
	parameter int WIDTH = rsa_pkg::DEFAULT_WIDTH
) (
	input  wire              i_clk,
	input  wire              i_rst,
	input  wire              i_start,
	input  wire [WIDTH-1:0]  i_n,
	input  wire [WIDTH-1:0]  i_b,
	output logic [WIDTH-1:0] o_t,
	output logic             o_done
);

	localparam int CW = $clog2(WIDTH + 1);
	localparam logic [CW-1:0] LAST = CW'(WIDTH - 1);

	rsa_pkg::unit_state_e state_r;
	logic [CW-1:0]        cnt_r;
	logic [WIDTH-1:0]     t_r;
	logic [WIDTH:0]       dbl;
	logic [WIDTH:0]       red;

	assign dbl = {t_r, 1'b0};  // t < n so 2t < 2n, one extra bit
	assign red = (dbl >= {1'b0, i_n}) ? dbl - {1'b0, i_n} : dbl;

	always_ff @(posedge i_clk or posedge i_rst) begin
		if (i_rst) begin
			state_r <= rsa_pkg::UNIT_IDLE;
			cnt_r   <= '0;
		end else begin
			case (state_r)
				rsa_pkg::UNIT_IDLE: begin
					if (i_start) begin
						state_r <= rsa_pkg::UNIT_RUN;
						cnt_r   <= '0;
					end
				end
				rsa_pkg::UNIT_RUN: begin
					cnt_r <= cnt_r + 1'b1;
					if (cnt_r == LAST)
						state_r <= rsa_pkg::UNIT_DONE;
				end
				default: state_r <= rsa_pkg::UNIT_IDLE;  // done lasts one cycle
			endcase
		end
	end

	always_ff @(posedge i_clk) begin
		if (state_r == rsa_pkg::UNIT_IDLE && i_start)
			t_r <= i_b;
		else if (state_r == rsa_pkg::UNIT_RUN)
			t_r <= red[WIDTH-1:0];
	end

	assign o_t    = t_r;
	assign o_done = (state_r == rsa_pkg::UNIT_DONE);

endmodule

`default_nettype wire

//--- rsa_mont_mul.sv
`timescale 1ns/100ps
`default_nettype none

// radix-2 montgomery product, m = a * b * 2^-WIDTH mod n
module rsa_mont_mul #(
	parameter int WIDTH = rsa_pkg::DEFAULT_WIDTH
) (
	input  wire              i_clk,
	input  wire              i_rst,
	input  wire              i_start,
	input  wire [WIDTH-1:0]  i_n,
	input  wire [WIDTH-1:0]  i_a,
	input  wire [WIDTH-1:0]  i_b,
	output logic [WIDTH-1:0] o_m,
	output logic             o_done
);

	localparam int CW = $clog2(WIDTH + 1);
	localparam logic [CW-1:0] LAST = CW'(WIDTH);

	rsa_pkg::unit_state_e state_r;
	logic [CW-1:0]        cnt_r;
	logic [WIDTH-1:0]     a_r;   // shifts right, lsb is the current bit
	logic [WIDTH-1:0]     b_r;
	logic [WIDTH:0]       m_r;   // partial result stays below 2n
	logic [WIDTH+1:0]     sum_b;
	logic [WIDTH+1:0]     sum_n;

	assign sum_b = {1'b0, m_r} + (a_r[0] ? {2'b00, b_r} : '0);
	assign sum_n = sum_b[0] ? sum_b + {2'b00, i_n} : sum_b;  // make it even

	always_ff @(posedge i_clk or posedge i_rst) begin
		if (i_rst) begin
			state_r <= rsa_pkg::UNIT_IDLE;
			cnt_r   <= '0;
		end else begin
			case (state_r)
				rsa_pkg::UNIT_IDLE: begin
					if (i_start) begin
						state_r <= rsa_pkg::UNIT_RUN;
						cnt_r   <= '0;
					end
				end
				rsa_pkg::UNIT_RUN: begin
					cnt_r <= cnt_r + 1'b1;
					if (cnt_r == LAST)
						state_r <= rsa_pkg::UNIT_DONE;
				end
				default: state_r <= rsa_pkg::UNIT_IDLE;
			endcase
		end
	end

	always_ff @(posedge i_clk) begin
		if (state_r == rsa_pkg::UNIT_IDLE && i_start) begin
			a_r <= i_a;
			b_r <= i_b;
			m_r <= '0;
		end else if (state_r == rsa_pkg::UNIT_RUN) begin
			if (cnt_r == LAST) begin
				// final conditional subtraction
				if (m_r >= {1'b0, i_n})
					m_r <= m_r - {1'b0, i_n};
			end else begin
				m_r <= sum_n[WIDTH+1:1];
				a_r <= a_r >> 1;
			end
		end
	end

	assign o_m    = m_r[WIDTH-1:0];
	assign o_done = (state_r == rsa_pkg::UNIT_DONE);

endmodule

`default_nettype wire

//--- rsa_core.sv
`timescale 1ns/100ps
`default_nettype none

// right-to-left square and multiply over the exponent bits
module rsa_core #(
	parameter int WIDTH = rsa_pkg::DEFAULT_WIDTH
) (
	input  wire              i_clk,
	input  wire              i_rst,
	input  wire              i_start,
	input  wire [WIDTH-1:0]  i_text,  // cipher text, below n
	input  wire [WIDTH-1:0]  i_n,
	input  wire [WIDTH-1:0]  i_d,
	output logic [WIDTH-1:0] o_result,
	output logic             o_finished,
	output logic             o_busy
);

	localparam int CW = $clog2(WIDTH + 1);
	localparam logic [CW-1:0] LAST_BIT = CW'(WIDTH - 1);

	rsa_pkg::core_state_e state_r;
	logic [CW-1:0]        bit_cnt_r;
	logic                 prep_start_r;
	logic                 sq_start_r;
	logic                 acc_start_r;
	logic                 finished_r;
	logic [WIDTH-1:0]     result_r;

	logic [WIDTH-1:0]     text_r;
	logic [WIDTH-1:0]     sq_r;   // text^(2^i) in montgomery form
	logic [WIDTH-1:0]     acc_r;  // plain, starts at one
	logic [WIDTH-1:0]     dsh_r;  // exponent, current bit at lsb

	logic [WIDTH-1:0]     prep_t;
	logic                 prep_done;
	logic [WIDTH-1:0]     sq_m;
	logic                 sq_done;
	logic [WIDTH-1:0]     acc_m;

	rsa_mod_prod #(.WIDTH(WIDTH)) mod_prod (
		.i_clk  (i_clk),
		.i_rst  (i_rst),
		.i_start(prep_start_r),
		.i_n    (i_n),
		.i_b    (text_r),
		.o_t    (prep_t),
		.o_done (prep_done)
	);

	rsa_mont_mul #(.WIDTH(WIDTH)) mont_acc (
		.i_clk  (i_clk),
		.i_rst  (i_rst),
		.i_start(acc_start_r),
		.i_n    (i_n),
		.i_a    (acc_r),
		.i_b    (sq_r),
		.o_m    (acc_m),
		.o_done ()
	);

	rsa_mont_mul #(.WIDTH(WIDTH)) mont_sq (
		.i_clk  (i_clk),
		.i_rst  (i_rst),
		.i_start(sq_start_r),
		.i_n    (i_n),
		.i_a    (sq_r),
		.i_b    (sq_r),
		.o_m    (sq_m),
		.o_done (sq_done)
	);

	always_ff @(posedge i_clk or posedge i_rst) begin
		if (i_rst) begin
			state_r      <= rsa_pkg::CORE_IDLE;
			bit_cnt_r    <= '0;
			prep_start_r <= 1'b0;
			sq_start_r   <= 1'b0;
			acc_start_r  <= 1'b0;
			finished_r   <= 1'b0;
			result_r     <= '0;
		end else begin
			finished_r <= 1'b0;
			case (state_r)
				rsa_pkg::CORE_IDLE: begin
					if (i_start) begin
						state_r      <= rsa_pkg::CORE_PREP;
						prep_start_r <= 1'b1;
					end
				end
				rsa_pkg::CORE_PREP: begin
					prep_start_r <= 1'b0;
					if (prep_done) begin
						state_r   <= rsa_pkg::CORE_PREMONT;
						bit_cnt_r <= '0;
					end
				end
				rsa_pkg::CORE_PREMONT: begin
					state_r     <= rsa_pkg::CORE_MONT;
					sq_start_r  <= 1'b1;
					acc_start_r <= dsh_r[0];  // multiply only on a set bit
				end
				rsa_pkg::CORE_MONT: begin
					sq_start_r  <= 1'b0;
					acc_start_r <= 1'b0;
					// both multipliers share one latency and the square one always runs
					if (sq_done)
						state_r <= rsa_pkg::CORE_CALC;
				end
				rsa_pkg::CORE_CALC: begin
					if (bit_cnt_r == LAST_BIT) begin
						state_r    <= rsa_pkg::CORE_IDLE;
						finished_r <= 1'b1;
						result_r   <= dsh_r[0] ? acc_m : acc_r;
					end else begin
						state_r   <= rsa_pkg::CORE_PREMONT;
						bit_cnt_r <= bit_cnt_r + 1'b1;
					end
				end
				default: state_r <= rsa_pkg::CORE_IDLE;
			endcase
		end
	end

	always_ff @(posedge i_clk) begin
		if (state_r == rsa_pkg::CORE_IDLE && i_start)
			text_r <= i_text;
		if (state_r == rsa_pkg::CORE_PREP && prep_done) begin
			sq_r  <= prep_t;
			acc_r <= {{(WIDTH-1){1'b0}}, 1'b1};
			dsh_r <= i_d;
		end
		if (state_r == rsa_pkg::CORE_CALC) begin
			sq_r  <= sq_m;
			dsh_r <= dsh_r >> 1;
			if (dsh_r[0])
				acc_r <= acc_m;  // product held until the next start
		end
	end

	assign o_result   = result_r;
	assign o_finished = finished_r;
	assign o_busy     = (state_r != rsa_pkg::CORE_IDLE);

endmodule

`default_nettype wire

//--- rsa_top.sv
`timescale 1ns/100ps
`default_nettype none

module rsa_top #(
	parameter int WIDTH = rsa_pkg::DEFAULT_WIDTH
) (
	input  wire              i_clk,
	input  wire              i_rst,
	input  wire              i_key_load,
	input  wire [WIDTH-1:0]  i_n,
	input  wire [WIDTH-1:0]  i_d,
	input  wire              i_start,
	input  wire [WIDTH-1:0]  i_text,
	output logic [WIDTH-1:0] o_result,
	output logic             o_finished,
	output logic             o_busy
);

	logic [WIDTH-1:0] key_n;
	logic [WIDTH-1:0] key_d;
	logic             core_busy;

	rsa_key_regs #(.WIDTH(WIDTH)) key_regs (
		.i_clk     (i_clk),
		.i_rst     (i_rst),
		.i_key_load(i_key_load),
		.i_n       (i_n),
		.i_d       (i_d),
		.i_busy    (core_busy),  // locks the key during a run
		.o_n       (key_n),
		.o_d       (key_d)
	);

	rsa_core #(.WIDTH(WIDTH)) core (
		.i_clk     (i_clk),
		.i_rst     (i_rst),
		.i_start   (i_start),
		.i_text    (i_text),
		.i_n       (key_n),
		.i_d       (key_d),
		.o_result  (o_result),
		.o_finished(o_finished),
		.o_busy    (core_busy)
	);

	assign o_busy = core_busy;

endmodule

`default_nettype wire

//--- rsa_properties.sv
`timescale 1ns/100ps
`default_nettype none

module rsa_properties (
	input wire                       i_clk,
	input wire                       i_rst,
	input wire rsa_pkg::core_state_e i_state,
	input wire                       i_prep_start,
	input wire                       i_sq_start,
	input wire                       i_acc_start,
	input wire                       i_finished,
	input wire                       i_busy
);

	a_finished_pulse: assert property (@(posedge i_clk) disable iff (i_rst)
		i_finished |=> !i_finished)
		else $error("o_finished high for more than one cycle");

	// one mapping start, only while mapping
	a_prep_start: assert property (@(posedge i_clk) disable iff (i_rst)
		i_prep_start |-> i_state == rsa_pkg::CORE_PREP && !i_sq_start && $past(!i_busy))
		else $error("mapping start outside its state");

	a_mont_start: assert property (@(posedge i_clk) disable iff (i_rst)
		(i_sq_start || i_acc_start) |->
			i_state == rsa_pkg::CORE_MONT && $past(i_state) == rsa_pkg::CORE_PREMONT)
		else $error("multiplier start outside the first mont cycle");

	a_after_reset: assert property (@(posedge i_clk)
		$fell(i_rst) |-> !i_busy && !i_finished)
		else $error("busy or finished high right after reset");

endmodule

bind rsa_core rsa_properties props_inst (
	.i_clk       (i_clk),
	.i_rst       (i_rst),
	.i_state     (state_r),
	.i_prep_start(prep_start_r),
	.i_sq_start  (sq_start_r),
	.i_acc_start (acc_start_r),
	.i_finished  (o_finished),
	.i_busy      (o_busy)
);

`default_nettype wire

//--- tb_rsa_top.sv
`timescale 1ns/100ps
`default_nettype none

module tb_rsa_top;

	localparam int WIDTH     = 32;  // 64-bit model below relies on this
	localparam int NUM_RUNS  = 32;  // 28 runs plus idle windows
	localparam int RUN_LIMIT = 3 * WIDTH * WIDTH;

	logic             i_clk;
	logic             i_rst;
	logic             i_key_load;
	logic [WIDTH-1:0] i_n;
	logic [WIDTH-1:0] i_d;
	logic             i_start;
	logic [WIDTH-1:0] i_text;
	logic [WIDTH-1:0] o_result;
	logic             o_finished;
	logic             o_busy;

	logic [31:0] lcg_state = 32'he2c4e1dd;
	int          errors = 0;
	int          test_errors = 0;  // error count when the test began
	int          tests = 0;
	int          failed_tests = 0;
	int          cycles = 0;
	int          pulses = 0;

	rsa_top #(.WIDTH(WIDTH)) rsa_top_inst (
		.i_clk     (i_clk),
		.i_rst     (i_rst),
		.i_key_load(i_key_load),
		.i_n       (i_n),
		.i_d       (i_d),
		.i_start   (i_start),
		.i_text    (i_text),
		.o_result  (o_result),
		.o_finished(o_finished),
		.o_busy    (o_busy)
	);

	initial begin
		i_clk = 1'b0;
		forever #10 i_clk = ~i_clk;
	end

	always @(posedge i_clk) begin
		cycles <= cycles + 1;
		if (o_finished)
			pulses <= pulses + 1;  // finish pulses seen so far
		if (cycles == NUM_RUNS * RUN_LIMIT) begin
			$display("timeout: simulation stopped after %0d cycles", cycles);
			$display("Errors found");
			$finish;
		end
	end

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	// reference: square and multiply, lsb first
	function automatic logic [WIDTH-1:0] modexp(input logic [63:0] base,
		input logic [63:0] exp, input logic [63:0] n);
		logic [63:0] r;
		logic [63:0] b;
		r = 64'd1 % n;
		b = base % n;
		for (int i = 0; i < WIDTH; i++) begin
			if (exp[i])
				r = (r * b) % n;
			b = (b * b) % n;
		end
		return r[WIDTH-1:0];
	endfunction

	task automatic check_result(input string sig, input logic [WIDTH-1:0] got,
		input logic [WIDTH-1:0] exp);
		if (got !== exp) begin
			errors++;
			$display("Mismatch at %0t: %s got %h, expected %h", $time, sig, got, exp);
		end
	endtask

	task automatic check_status(input string sig, input logic got, input logic exp);
		if (got !== exp) begin
			errors++;
			$display("Mismatch at %0t: %s got %b, expected %b", $time, sig, got, exp);
		end
	endtask

	task automatic end_test(input string name);
		tests++;
		if (errors == test_errors) begin
			$display("test %s: passed", name);
		end else begin
			failed_tests++;
			$display("test %s: failed, %0d bad checks", name, errors - test_errors);
		end
		test_errors = errors;
	endtask

	task automatic reset_dut();
		i_rst <= 1'b1;
		repeat (2) @(posedge i_clk);
		i_rst <= 1'b0;
		@(posedge i_clk);
		check_status("o_busy", o_busy, 1'b0);
		check_status("o_finished", o_finished, 1'b0);
		check_result("o_result", o_result, '0);
	endtask

	task automatic load_key(input logic [WIDTH-1:0] n, input logic [WIDTH-1:0] d);
		@(posedge i_clk);
		i_key_load <= 1'b1;
		i_n        <= n;
		i_d        <= d;
		@(posedge i_clk);
		i_key_load <= 1'b0;
	endtask

	task automatic start_run(input logic [WIDTH-1:0] text);
		@(posedge i_clk);
		i_start <= 1'b1;
		i_text  <= text;
		@(posedge i_clk);
		i_start <= 1'b0;
	endtask

	// wait for the finish pulse, then check result and busy
	task automatic finish_and_check(input logic [WIDTH-1:0] exp);
		int waited;
		waited = 0;
		@(posedge i_clk);
		while (!o_finished && waited < RUN_LIMIT) begin
			@(posedge i_clk);
			waited++;
		end
		if (!o_finished) begin
			errors++;
			$display("no o_finished pulse within %0d cycles at %0t", RUN_LIMIT, $time);
		end else begin
			check_result("o_result", o_result, exp);
			check_status("o_busy", o_busy, 1'b0);
		end
	endtask

	initial begin : stimulus
		logic [WIDTH-1:0] n;
		logic [WIDTH-1:0] d;
		logic [WIDTH-1:0] n2;
		logic [WIDTH-1:0] d2;
		logic [WIDTH-1:0] text;
		int               pulses_before;
		i_rst      = 1'b1;
		i_key_load = 1'b0;
		i_n        = '0;
		i_d        = '0;
		i_start    = 1'b0;
		i_text     = '0;
		reset_dut();
		end_test("reset");

		for (int k = 0; k < 20; k++) begin
			n    = lcg_next() | 32'h8000_0001;  // odd, top bit set
			d    = lcg_next();
			text = lcg_next() % n;
			load_key(n, d);
			start_run(text);
			finish_and_check(modexp(text, d, n));
		end
		end_test("random keys");

		n    = lcg_next() | 32'h8000_0001;
		text = lcg_next() % n;
		load_key(n, '0);
		start_run(text);
		finish_and_check(1);
		load_key(n, 1);
		start_run(text);
		finish_and_check(text);
		end_test("exponent zero and one");

		d = '1;
		load_key(n, d);
		start_run(n - 1);
		finish_and_check(modexp(n - 1, d, n));
		end_test("full exponent");

		n    = lcg_next() | 32'h8000_0001;
		d    = lcg_next();
		n2   = lcg_next() | 32'h8000_0001;
		d2   = lcg_next();
		text = lcg_next() % ((n < n2) ? n : n2);  // valid for both keys
		load_key(n, d);
		start_run(text);
		repeat (10) @(posedge i_clk);
		load_key(n2, d2);  // core busy, must be dropped
		finish_and_check(modexp(text, d, n));
		start_run(text);
		finish_and_check(modexp(text, d, n));
		load_key(n2, d2);
		start_run(text);
		finish_and_check(modexp(text, d2, n2));
		end_test("key lock");

		@(posedge i_clk);
		pulses_before = pulses;
		start_run(text);
		repeat (10) @(posedge i_clk);
		start_run(lcg_next() % n2);
		finish_and_check(modexp(text, d2, n2));
		repeat (4 * WIDTH) @(posedge i_clk);
		check_status("o_busy", o_busy, 1'b0);
		if (pulses != pulses_before + 1) begin
			errors++;
			$display("expected one o_finished pulse, counted %0d", pulses - pulses_before);
		end
		end_test("start while busy");

		start_run(text);
		repeat (20) @(posedge i_clk);
		reset_dut();
		end_test("reset in run");

		$display("summary: %0d tests, %0d failed, %0d bad checks", tests, failed_tests, errors);
		if (errors == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

endmodule

`default_nettype wire

//--- project.f
rsa_pkg.sv
rsa_key_regs.sv
rsa_mod_prod.sv
rsa_mont_mul.sv
rsa_core.sv
rsa_top.sv
rsa_properties.sv
tb_rsa_top.sv

//--- Bender.yml
package:
  name: rsa_modexp

sources:
  - rsa_pkg.sv
  - rsa_key_regs.sv
  - rsa_mod_prod.sv
  - rsa_mont_mul.sv
  - rsa_core.sv
  - rsa_top.sv
  - target: simulation
    files:
      - rsa_properties.sv
      - tb_rsa_top.sv
